/* design/exec_config.svh */
/*
 * build-time sizes for the execute core
 * operand width, physical register count and index width,
 * multiplier latency in cycles
 */
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

`define DATA_WIDTH      32  // operand / result width
`define PHYS_REGS       32  // physical register count
`define PHYS_IDX_WIDTH  5   // must cover PHYS_REGS

// acceptance to req on the multiplier, 2 or more
`define MUL_LATENCY     3

`endif

/* design/isa_pkg.sv */
/*
 * instruction set types
 * opcode encoding and functional unit select
 */
`default_nettype none

package isa_pkg;

    // 3-bit opcode, op_mul is the only multiplier op
    typedef enum logic [2:0] {
        op_li  = 3'd0,  // load immediate
        op_add = 3'd1,
        op_sub = 3'd2,
        op_and = 3'd3,
        op_or  = 3'd4,
        op_xor = 3'd5,
        op_sll = 3'd6,  // shift left by src2[4:0]
        op_mul = 3'd7
    } alu_op_t;

    typedef enum logic {
        fu_alu  = 1'b0,
        fu_mult = 1'b1
    } fu_sel_t;  // steering target

endpackage

`default_nettype wire

/* design/core_pkg.sv */
/*
 * core datapath types
 * register index, data word, CDB arbiter state encoding
 */
`default_nettype none

`include "exec_config.svh"

package core_pkg;

    // physical register index, also the CDB tag
    typedef logic [`PHYS_IDX_WIDTH-1:0] phys_idx_t;

    typedef logic [`DATA_WIDTH-1:0] data_t;  // operand / result word

    // arbiter sequence
    //   idle      -> waiting for any req
    //   broadcast -> one cycle on the CDB, ack high
    //   release   -> ack held until granted req drops
    typedef enum logic [1:0] {
        arb_idle      = 2'd0,
        arb_broadcast = 2'd1,
        arb_release   = 2'd2
    } arb_state_t;

endpackage

`default_nettype wire

/* design/phys_regfile.sv */
/*
 * physical register file
 * two combinational read ports, one write port fed by the CDB
 */
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module phys_regfile (
    input  logic                clock,
    input  logic                reset,
    input  core_pkg::phys_idx_t rd_idx_a,
    input  core_pkg::phys_idx_t rd_idx_b,
    output core_pkg::data_t     rd_data_a,
    output core_pkg::data_t     rd_data_b,
    input  logic                wr_en,      // cdb_valid
    input  core_pkg::phys_idx_t wr_idx,     // cdb_tag
    input  core_pkg::data_t     wr_data     // cdb_data
);
    import core_pkg::*;

    data_t regs [`PHYS_REGS];

    // no bypass, a write shows up the cycle after
    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `PHYS_REGS; i++) begin
                regs[i] <= '0;   // all registers start at zero
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* design/issue_unit.sv */
/*
 * issue steering
 * opcode to unit select, ready gating, one start pulse per accepted op
 */
`timescale 1ns/1ps
`default_nettype none

module issue_unit (
    input  logic             clock,
    input  logic             reset,
    input  logic             issue_valid,
    input  isa_pkg::alu_op_t issue_op,
    output logic             issue_ready,
    input  logic             alu_busy,
    input  logic             mult_busy,
    output logic             alu_start,
    output logic             mult_start
);
    import isa_pkg::*;

    fu_sel_t sel;        // decoded target unit
    logic    accept;

    assign sel = (issue_op == op_mul) ? fu_mult : fu_alu;

    // the unselected unit may stay busy
    always_comb begin
        if (sel == fu_mult) begin
            issue_ready = !mult_busy;
        end else begin
            issue_ready = !alu_busy;   // busy rises on the start edge
        end
    end

    assign accept     = issue_valid && issue_ready;
    assign alu_start  = accept && (sel == fu_alu);   // unit latches on this edge
    assign mult_start = accept && (sel == fu_mult);

endmodule

`default_nettype wire

/* design/alu_unit.sv */
/*
 * single-cycle integer unit
 * li / add / sub / and / or / xor / sll, result held for the CDB
 * four-phase req/ack toward the arbiter
 */
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  logic                clock,
    input  logic                reset,
    input  logic                start,
    input  isa_pkg::alu_op_t    op,
    input  core_pkg::phys_idx_t dest,
    input  core_pkg::data_t     src_a,
    input  core_pkg::data_t     src_b,
    input  core_pkg::data_t     imm,
    output logic                busy,
    output logic                req,
    input  logic                ack,
    output core_pkg::data_t     result,
    output core_pkg::phys_idx_t tag
);
    import core_pkg::*;
    import isa_pkg::*;

    typedef enum logic [1:0] {
        alu_idle      = 2'd0,
        alu_wait_ack  = 2'd1,   // req high, result on hold
        alu_wait_drop = 2'd2    // req low, ack still high
    } alu_state_t;

    alu_state_t state;
    data_t      alu_out;

    ////////////////////////////////////////////////////////////////////////////
    // datapath

    always_comb begin
        case (op)
            op_li:   alu_out = imm;
            op_add:  alu_out = src_a + src_b;   // wraps at data width
            op_sub:  alu_out = src_a - src_b;
            op_and:  alu_out = src_a & src_b;
            op_or:   alu_out = src_a | src_b;
            op_xor:  alu_out = src_a ^ src_b;
            op_sll:  alu_out = src_a << src_b[4:0];
            default: alu_out = '0;              // op_mul never steered here
        endcase
    end

    always_ff @(posedge clock) begin
        if (start) begin
            result <= alu_out;
            tag    <= dest;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // handshake

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= alu_idle;
        end else begin
            case (state)
                alu_idle:      if (start) state <= alu_wait_ack;
                alu_wait_ack:  if (ack)   state <= alu_wait_drop;  // broadcast done
                alu_wait_drop: if (!ack)  state <= alu_idle;
                default:                  state <= alu_idle;
            endcase
        end
    end

    assign req  = (state == alu_wait_ack);
    assign busy = (state != alu_idle);   // stays up through the ack release

endmodule

`default_nettype wire

/* design/mult_unit.sv */
/*
 * fixed-latency multiplier
 * operands captured on start, low half of the product after the count
 * four-phase req/ack toward the arbiter
 */
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module mult_unit (
    input  logic                clock,
    input  logic                reset,
    input  logic                start,
    input  core_pkg::phys_idx_t dest,
    input  core_pkg::data_t     src_a,
    input  core_pkg::data_t     src_b,
    output logic                busy,
    output logic                req,
    input  logic                ack,
    output core_pkg::data_t     result,
    output core_pkg::phys_idx_t tag
);
    import core_pkg::*;

    localparam int CNT_W = $clog2(`MUL_LATENCY + 1);

    typedef enum logic [1:0] {
        mul_idle      = 2'd0,
        mul_calc      = 2'd1,   // counting down the latency
        mul_wait_ack  = 2'd2,
        mul_wait_drop = 2'd3
    } mul_state_t;

    mul_state_t       state;
    logic [CNT_W-1:0] cnt;
    data_t            op_a;
    data_t            op_b;
    data_t            product;   // low half only

    assign product = op_a * op_b;

    // operand, tag and result registers
    always_ff @(posedge clock) begin
        if (start) begin
            op_a <= src_a;
            op_b <= src_b;
            tag  <= dest;
        end
        if (state == mul_calc && cnt == CNT_W'(1)) begin
            result <= product;   // held steady through the handshake
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // req rises MUL_LATENCY cycles after start

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= mul_idle;
            cnt   <= '0;
        end else begin
            case (state)
                mul_idle: begin
                    if (start) begin
                        state <= mul_calc;
                        cnt   <= CNT_W'(`MUL_LATENCY - 1);
                    end
                end
                mul_calc: begin
                    cnt <= cnt - CNT_W'(1);
                    if (cnt == CNT_W'(1)) state <= mul_wait_ack;
                end
                mul_wait_ack:  if (ack)  state <= mul_wait_drop;
                mul_wait_drop: if (!ack) state <= mul_idle;   // arbiter let go
                default:                 state <= mul_idle;
            endcase
        end
    end

    assign req  = (state == mul_wait_ack);
    assign busy = (state != mul_idle);

endmodule

`default_nettype wire

/* design/cdb_arbiter.sv */
/*
 * CDB arbiter
 * round-robin between ALU and multiplier, four-phase ack per unit,
 * one broadcast cycle per grant onto the CDB and register write port
 */
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
    input  logic                clock,
    input  logic                reset,
    input  logic                alu_req,
    input  core_pkg::data_t     alu_result,
    input  core_pkg::phys_idx_t alu_tag,
    output logic                alu_ack,
    input  logic                mult_req,
    input  core_pkg::data_t     mult_result,
    input  core_pkg::phys_idx_t mult_tag,
    output logic                mult_ack,
    output logic                cdb_valid,
    output core_pkg::phys_idx_t cdb_tag,
    output core_pkg::data_t     cdb_data
);
    import core_pkg::*;

    arb_state_t state;
    logic       last_served;   // 0 alu, 1 mult; also the live grant
    logic       pick;          // winner if a grant starts now
    logic       granted_req;
    logic       holding;

    ////////////////////////////////////////////////////////////////////////////
    // selection

    // on a tie the unit not served last wins
    always_comb begin
        if (alu_req && mult_req) begin
            pick = !last_served;
        end else begin
            pick = mult_req;   // only one or none asking
        end
    end

    assign granted_req = last_served ? mult_req : alu_req;

    ////////////////////////////////////////////////////////////////////////////
    // grant sequence

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= arb_idle;
            last_served <= 1'b1;   // alu wins the first tie
        end else begin
            case (state)
                arb_idle: begin
                    if (alu_req || mult_req) begin
                        state       <= arb_broadcast;
                        last_served <= pick;
                    end
                end
                arb_broadcast: state <= arb_release;   // exactly one cycle
                arb_release: begin
                    if (!granted_req) state <= arb_idle;  // unit saw ack
                end
                default: state <= arb_idle;
            endcase
        end
    end

    assign holding  = (state != arb_idle);
    assign alu_ack  = holding && !last_served;
    assign mult_ack = holding && last_served;

    // granted unit holds result and tag steady while req is up
    assign cdb_valid = (state == arb_broadcast);
    assign cdb_tag   = last_served ? mult_tag : alu_tag;
    assign cdb_data  = last_served ? mult_result : alu_result;

endmodule

`default_nettype wire

/* design/exec_core.sv */
/*
 * execute / complete top level
 * issue unit, physical register file, ALU, multiplier, CDB arbiter
 */
`timescale 1ns/1ps
`default_nettype none

module exec_core (
    input  logic                clock,
    input  logic                reset,
    // scalar issue port
    input  logic                issue_valid,
    input  isa_pkg::alu_op_t    issue_op,
    input  core_pkg::phys_idx_t issue_dest,
    input  core_pkg::phys_idx_t issue_src1,
    input  core_pkg::phys_idx_t issue_src2,
    input  core_pkg::data_t     issue_imm,
    output logic                issue_ready,
    // common data bus
    output logic                cdb_valid,
    output core_pkg::phys_idx_t cdb_tag,
    output core_pkg::data_t     cdb_data
);
    import core_pkg::*;

    data_t     rd_data_a;   // src1 value
    data_t     rd_data_b;   // src2 value

    logic      alu_start;
    logic      alu_busy;
    logic      alu_req;
    logic      alu_ack;
    data_t     alu_result;
    phys_idx_t alu_tag;

    logic      mult_start;
    logic      mult_busy;
    logic      mult_req;
    logic      mult_ack;
    data_t     mult_result;
    phys_idx_t mult_tag;

    ////////////////////////////////////////////////////////////////////////////
    // issue and operand read

    issue_unit issue_unit_i (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_ready (issue_ready),
        .alu_busy    (alu_busy),
        .mult_busy   (mult_busy),
        .alu_start   (alu_start),
        .mult_start  (mult_start)
    );

    // read addresses straight from the issue port, write from CDB
    phys_regfile phys_regfile_i (
        .clock     (clock),
        .reset     (reset),
        .rd_idx_a  (issue_src1),
        .rd_idx_b  (issue_src2),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (cdb_valid),
        .wr_idx    (cdb_tag),
        .wr_data   (cdb_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // functional units

    alu_unit alu_unit_i (
        .clock  (clock),
        .reset  (reset),
        .start  (alu_start),
        .op     (issue_op),
        .dest   (issue_dest),
        .src_a  (rd_data_a),
        .src_b  (rd_data_b),
        .imm    (issue_imm),
        .busy   (alu_busy),
        .req    (alu_req),
        .ack    (alu_ack),
        .result (alu_result),
        .tag    (alu_tag)
    );

    mult_unit mult_unit_i (
        .clock  (clock),
        .reset  (reset),
        .start  (mult_start),
        .dest   (issue_dest),
        .src_a  (rd_data_a),
        .src_b  (rd_data_b),
        .busy   (mult_busy),
        .req    (mult_req),
        .ack    (mult_ack),
        .result (mult_result),
        .tag    (mult_tag)
    );

    ////////////////////////////////////////////////////////////////////////////
    // completion

    cdb_arbiter cdb_arbiter_i (
        .clock       (clock),
        .reset       (reset),
        .alu_req     (alu_req),
        .alu_result  (alu_result),
        .alu_tag     (alu_tag),
        .alu_ack     (alu_ack),
        .mult_req    (mult_req),
        .mult_result (mult_result),
        .mult_tag    (mult_tag),
        .mult_ack    (mult_ack),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_data    (cdb_data)
    );

endmodule

`default_nettype wire

/* sim/exec_core_tb_tasks.svh */
/*
 * testbench helpers
 * issue with stall timeout, waits for broadcasts, mismatch report
 */
`ifndef EXEC_CORE_TB_TASKS_SVH
`define EXEC_CORE_TB_TASKS_SVH

// one op through the valid/ready port, returns the cycles spent stalled
task automatic send_op(input alu_op_t op, input phys_idx_t dest, input phys_idx_t src1,
                       input phys_idx_t src2, input data_t imm, output int stalls);
    int    waited;
    data_t expected;
    if (op != op_li && (issued_count[src1] != seen_count[src1] ||
                        issued_count[src2] != seen_count[src2])) begin
        $display("operation for tag %0d issued before its sources were broadcast", dest);
        abort_run();
    end
    if (issued_count[dest] != seen_count[dest]) begin
        $display("tag %0d reused while its previous result is outstanding", dest);
        abort_run();
    end
    expected    = model_result(op, model_regs[src1], model_regs[src2], imm);
    issue_valid = 1'b1;
    issue_op    = op;
    issue_dest  = dest;
    issue_src1  = src1;
    issue_src2  = src2;
    issue_imm   = imm;
    waited      = 0;
    @(posedge clock);
    while (!issue_ready) begin           // pre-edge value, stable here
        waited++;
        if (waited > ISSUE_TIMEOUT) begin
            $display("issue_ready stayed low for %0d cycles at %0t", waited, $time);
            abort_run();
        end
        @(posedge clock);
    end
    #1;
    issue_valid         = 1'b0;
    exp_data[dest]      = expected;      // accepted on that edge
    issued_count[dest]  = issued_count[dest] + 1;
    stalls              = waited;
endtask

// until the monitor has seen this tag on the CDB
task automatic wait_tag(input phys_idx_t tag);
    int cycles;
    cycles = 0;
    while (issued_count[tag] != seen_count[tag]) begin
        if (cycles >= RESULT_TIMEOUT) begin
            $display("tag %0d was never broadcast on the CDB", tag);
            abort_run();
        end
        @(posedge clock);
        #1;
        cycles++;
    end
endtask

task automatic drain_results();
    int cycles;
    cycles = 0;
    while (pending_total() != 0) begin
        if (cycles >= RESULT_TIMEOUT) begin
            $display("%0d results never came back on the CDB", pending_total());
            abort_run();
        end
        @(posedge clock);
        #1;
        cycles++;
    end
endtask

task automatic idle_cycles(input int n);
    repeat (n) @(posedge clock);
    #1;                                  // back to drive point
endtask

task automatic report_mismatch(input string name, input data_t expected, input data_t actual);
    $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
    abort_run();
endtask

`endif

/* sim/exec_core_tb.sv */
/*
 * testbench for the execute core
 * clock, reset, DUT, register model, CDB monitor, directed stimulus
 */
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module exec_core_tb;
    import isa_pkg::*;
    import core_pkg::*;

    localparam int ISSUE_TIMEOUT  = 50;   // cycles stalled on issue_ready
    localparam int RESULT_TIMEOUT = 100;  // cycles waiting on a broadcast

    logic      clock;
    logic      reset;
    logic      issue_valid;
    alu_op_t   issue_op;
    phys_idx_t issue_dest;
    phys_idx_t issue_src1;
    phys_idx_t issue_src2;
    data_t     issue_imm;
    logic      issue_ready;
    logic      cdb_valid;
    phys_idx_t cdb_tag;
    data_t     cdb_data;

    integer seed;
    // register model and per-tag bookkeeping
    data_t   model_regs   [`PHYS_REGS] = '{default: '0};
    data_t   exp_data     [`PHYS_REGS] = '{default: '0};
    int      issued_count [`PHYS_REGS] = '{default: 0};
    int      seen_count   [`PHYS_REGS] = '{default: 0};
    alu_op_t alu_ops      [6] = '{op_add, op_sub, op_and, op_or, op_xor, op_sll};

    exec_core exec_core_i (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_dest  (issue_dest),
        .issue_src1  (issue_src1),
        .issue_src2  (issue_src2),
        .issue_imm   (issue_imm),
        .issue_ready (issue_ready),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_data    (cdb_data)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;   // 10 ns
    end

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    // reference results straight from the opcode rules
    function automatic data_t model_result(input alu_op_t op, input data_t a,
                                           input data_t b, input data_t imm);
        case (op)
            op_li:   return imm;
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << b[4:0];
            op_mul:  return data_t'(a * b);   // low word of product
            default: return '0;
        endcase
    endfunction

    function automatic int pending_total();
        int n;
        n = 0;
        for (int i = 0; i < `PHYS_REGS; i++) begin
            n += issued_count[i] - seen_count[i];
        end
        return n;
    endfunction

    // one of the li-loaded registers 1..8
    function automatic phys_idx_t pick_src();
        return phys_idx_t'(1 + ($unsigned($random(seed)) % 8));
    endfunction

    `include "exec_core_tb_tasks.svh"

    ////////////////////////////////////////////////////////////////////////////
    // CDB checks

    cdb_one_cycle: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |=> !cdb_valid)
        else report_mismatch("cdb_valid", '0, 'd1);

    ready_known: assert property (@(posedge clock) disable iff (reset)
        !$isunknown(issue_ready))
        else begin
            $display("issue_ready is unknown at %0t", $time);
            abort_run();
        end

    // every broadcast matches exactly one outstanding op
    always @(posedge clock) begin
        if (!reset && cdb_valid) begin
            assert (issued_count[cdb_tag] > seen_count[cdb_tag]) else begin
                $display("tag %0d broadcast at %0t with nothing outstanding", cdb_tag, $time);
                abort_run();
            end
            assert (cdb_data == exp_data[cdb_tag])
                else report_mismatch("cdb_data", exp_data[cdb_tag], cdb_data);
            model_regs[cdb_tag] <= exp_data[cdb_tag];   // expected value feeds the model
            seen_count[cdb_tag] <= seen_count[cdb_tag] + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    initial begin
        int stalls;
        seed        = 32'hd8a9;
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue_op    = op_li;
        issue_dest  = '0;
        issue_src1  = '0;
        issue_src2  = '0;
        issue_imm   = '0;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        assert (cdb_valid == 1'b0) else report_mismatch("cdb_valid", '0, cdb_valid);
        assert (issue_ready == 1'b1) else report_mismatch("issue_ready", 'd1, issue_ready);

        // back-to-back load immediates into r1..r8
        for (int r = 1; r <= 8; r++) begin
            send_op(op_li, phys_idx_t'(r), '0, '0, data_t'($random(seed)), stalls);
        end
        drain_results();

        // each ALU op once into r9..r14
        for (int i = 0; i < 6; i++) begin
            send_op(alu_ops[i], phys_idx_t'(9 + i), pick_src(), pick_src(), '0, stalls);
        end
        drain_results();

        // multiplies into r15..r17
        for (int i = 0; i < 3; i++) begin
            send_op(op_mul, phys_idx_t'(15 + i), pick_src(), pick_src(), '0, stalls);
        end
        drain_results();

        // ALU op lands at varying offsets behind a multiply
        for (int gap = 0; gap < 4; gap++) begin
            idle_cycles(4);
            send_op(op_mul, phys_idx_t'(18 + gap), pick_src(), pick_src(), '0, stalls);
            if (gap > 0) idle_cycles(gap);
            send_op(op_xor, phys_idx_t'(22 + gap), pick_src(), pick_src(), '0, stalls);
            wait_tag(phys_idx_t'(18 + gap));
            wait_tag(phys_idx_t'(22 + gap));
        end
        drain_results();
        idle_cycles(4);   // let both handshakes return to idle

        // multiplier back-pressure while the ALU keeps flowing
        send_op(op_mul, 5'd26, 5'd1, 5'd2, '0, stalls);
        send_op(op_add, 5'd27, 5'd3, 5'd4, '0, stalls);
        assert (stalls == 0) else report_mismatch("issue_ready", 'd1, '0);
        assert (issued_count[26] != seen_count[26]) else begin
            $display("multiply finished before the ALU op could overlap it");
            abort_run();
        end
        send_op(op_mul, 5'd28, 5'd5, 5'd6, '0, stalls);
        assert (stalls > 0) else begin
            $display("second multiply accepted with the multiplier still busy");
            abort_run();
        end
        assert (issued_count[26] == seen_count[26]) else begin
            $display("second multiply accepted before the first one was broadcast");
            abort_run();
        end

        drain_results();
        idle_cycles(4);
        if (pending_total() == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("%0d results still outstanding at the end of the run", pending_total());
            abort_run();
        end
    end

endmodule

`default_nettype wire

/* exec_core.f */
+incdir+design
+incdir+sim
design/isa_pkg.sv
design/core_pkg.sv
design/phys_regfile.sv
design/issue_unit.sv
design/alu_unit.sv
design/mult_unit.sv
design/cdb_arbiter.sv
design/exec_core.sv
sim/exec_core_tb.sv

/* Bender.yml */
package:
  name: exec_core

sources:
  - include_dirs:
      - design
    files:
      - design/isa_pkg.sv
      - design/core_pkg.sv
      - design/phys_regfile.sv
      - design/issue_unit.sv
      - design/alu_unit.sv
      - design/mult_unit.sv
      - design/cdb_arbiter.sv
      - design/exec_core.sv
  - target: simulation
    include_dirs:
      - design
      - sim
    files:
      - sim/exec_core_tb.sv
